//--- source/trace_defs.svh
//////////////////////////////////////////////////
// sizing constants for the trace cache
// include in any file that sizes trace lines,
// the line array or the use counters
//////////////////////////////////////////////////

`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

`define TC_NUM_LINES	8	// lines in the fully associative store
`define TC_LINE_SLOTS	4	// instructions per trace line
`define TC_PC_BITS		32

// replacement aging
`define TC_AGE_INTERVAL	64	// cycles between use count decrements
`define TC_USE_MAX		7	// use count saturates here
`define TC_USE_FILL		2	// use count given to a freshly filled line

`endif

//--- source/trace_pkg.sv
//////////////////////////////////////////////////
// shared types for the trace cache
// retired instructions, trace lines, line write
// requests and lookup results
// import with trace_pkg::* in the module header
//////////////////////////////////////////////////

`default_nettype none

`include "trace_defs.svh"

package trace_pkg;

	typedef logic [`TC_PC_BITS-1:0] pc_t;
	typedef logic [$clog2(`TC_NUM_LINES)-1:0] line_idx_t;
	typedef logic [`TC_LINE_SLOTS-1:0] slot_mask_t;	// one bit per slot

	typedef enum logic [1:0] {
		INS_PLAIN,
		INS_JUMP,
		INS_CALL,
		INS_RETURN
	} ins_kind_t;

	typedef struct packed {
		pc_t		pc;
		logic [31:0]insn;
		logic		short_ins;	// compressed, 2 bytes
		ins_kind_t	kind;
		pc_t		target;		// taken destination for jump/call/return
		logic		will_trap;
	} trace_ins_t;

	// slot 0 holds the instruction at the tag pc
	typedef trace_ins_t [`TC_LINE_SLOTS-1:0] trace_line_t;

	typedef struct packed {
		logic		valid;		// one cycle strobe
		pc_t		tag;
		slot_mask_t	mask;
		trace_line_t data;
		pc_t		next_pc;	// where fetch goes after this line
	} line_write_t;

	typedef struct packed {
		logic		hit;
		line_idx_t	idx;
		slot_mask_t	mask;
		trace_line_t data;
		pc_t		next_pc;
	} lookup_t;

endpackage

`default_nettype wire

//--- source/trace_line_builder.sv
//////////////////////////////////////////////////
// line builder for the trace cache
// packs one retired instruction per cycle into
// trace lines and issues a write request when a
// line closes (full, call/return, pc break)
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "trace_defs.svh"

module trace_line_builder import trace_pkg::*; (
	input  wire logic	clk,
	input  wire logic	reset,
	input  wire logic	invalidate,
	input  wire logic	retire_valid,
	input  wire trace_ins_t	retire_ins,
	output line_write_t	line_wr
);

	localparam int SLOT_BITS = $clog2(`TC_LINE_SLOTS);

	// sequential pc rule
	function automatic pc_t next_pc_of(trace_ins_t ins);
		if (ins.kind != INS_PLAIN)
			return ins.target;
		return ins.pc + (ins.short_ins ? pc_t'(2) : pc_t'(4));
	endfunction

	logic			open_valid;		// a partial line is being built
	pc_t			open_tag;
	slot_mask_t		open_mask;
	trace_line_t	open_line;
	logic [SLOT_BITS-1:0]open_slot;	// next free slot
	pc_t			expect_pc;		// pc that continues the open line

	// a second completed line waiting for the write port
	line_write_t	pend;

	trace_ins_t		ins_st;
	logic			accept, brk, start_new, closes;
	logic [SLOT_BITS-1:0]slot;
	slot_mask_t		new_mask;
	trace_line_t	new_line;
	pc_t			new_tag;
	line_write_t	wr_brk, wr_end, wr_first, wr_second;

	assign accept = retire_valid && !retire_ins.will_trap;
	assign brk = accept && open_valid && retire_ins.pc != expect_pc;
	assign start_new = !open_valid || brk;
	assign slot = start_new ? '0 : open_slot;
	assign new_tag = start_new ? retire_ins.pc : open_tag;

	assign closes = accept && (slot == SLOT_BITS'(`TC_LINE_SLOTS-1) ||
		retire_ins.kind == INS_CALL || retire_ins.kind == INS_RETURN);

	always_comb begin
		ins_st = retire_ins;
		ins_st.will_trap = 1'b0;	// only non trapping ones get stored
		new_mask = (start_new ? '0 : open_mask) | (slot_mask_t'(1) << slot);
		new_line = start_new ? '0 : open_line;
		new_line[slot] = ins_st;
	end

	// old line cut off by a pc break, continues at the expected pc
	assign wr_brk = '{valid: brk, tag: open_tag, mask: open_mask,
		data: open_line, next_pc: expect_pc};

	// line finished by this instruction
	assign wr_end = '{valid: closes, tag: new_tag, mask: new_mask,
		data: new_line, next_pc: next_pc_of(retire_ins)};

	// a break followed by a call/return closes two lines in one cycle,
	// the second one goes out a cycle later. a break needs an open line,
	// which is never left behind when pend fills, so pend never meets
	// both a break and an end together
	always_comb begin
		if (pend.valid) begin
			wr_first = pend;
			wr_second = wr_brk.valid ? wr_brk : wr_end;
		end else if (wr_brk.valid) begin
			wr_first = wr_brk;
			wr_second = wr_end;
		end else begin
			wr_first = wr_end;
			wr_second = wr_brk;		// not valid here
		end
	end

	always_ff @(posedge clk) begin
		if (reset || invalidate) begin
			open_valid <= 1'b0;
			line_wr.valid <= 1'b0;
			pend.valid <= 1'b0;
		end else begin
			line_wr <= wr_first;
			pend <= wr_second;
			if (retire_valid && retire_ins.will_trap)
				open_valid <= 1'b0;		// trap drops the partial line
			else if (accept)
				open_valid <= !closes;
		end
	end

	// partial line contents, only meaningful while open_valid
	always_ff @(posedge clk) begin
		if (accept) begin
			open_tag <= new_tag;
			open_mask <= new_mask;
			open_line <= new_line;
			open_slot <= slot + 1'b1;
			expect_pc <= next_pc_of(retire_ins);
		end
	end

endmodule

`default_nettype wire

//--- source/trace_line_store.sv
//////////////////////////////////////////////////
// line store for the trace cache
// fully associative array of trace lines with a
// combinational pc match and one-hot read
// victims come from per line use counters that
// the fetch stage bumps and a timer ages
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "trace_defs.svh"

module trace_line_store import trace_pkg::*; (
	input  wire logic	clk,
	input  wire logic	reset,
	input  wire logic	invalidate,
	input  wire line_write_t	line_wr,
	input  wire pc_t	fetch_pc,
	input  wire logic	use_bump,
	input  wire line_idx_t	use_bump_idx,
	output lookup_t		lookup
);

	localparam int NUM = `TC_NUM_LINES;
	localparam int USE_BITS = $clog2(`TC_USE_MAX+1);
	localparam int AGE_BITS = $clog2(`TC_AGE_INTERVAL);

	// per line state
	logic [NUM-1:0]valid_q;
	pc_t			tag_q[NUM];
	slot_mask_t		mask_q[NUM];
	trace_line_t	data_q[NUM];
	pc_t			next_q[NUM];
	logic [USE_BITS-1:0]use_q[NUM];

	logic [NUM-1:0]match;	// fetch pc hits
	logic [NUM-1:0]dup;		// incoming tag already present
	logic			victim_ok;
	line_idx_t		victim;
	logic			fill;
	logic [AGE_BITS-1:0]age_cnt;
	logic			age_tick;

	always_comb begin
		for (int i = 0; i < NUM; i++) begin
			match[i] = valid_q[i] && tag_q[i] == fetch_pc;	// associative match
			dup[i] = valid_q[i] && tag_q[i] == line_wr.tag;
		end
	end

	// tags are unique, so at most one line matches and an OR mux reads it
	always_comb begin
		lookup = '0;
		for (int i = 0; i < NUM; i++) begin
			if (match[i]) begin
				lookup.hit = 1'b1;
				lookup.idx |= line_idx_t'(i);
				lookup.mask |= mask_q[i];
				lookup.data |= data_q[i];
				lookup.next_pc |= next_q[i];
			end
		end
	end

	// lowest invalid line first, then lowest idle line not being fetched
	always_comb begin
		victim_ok = 1'b0;
		victim = '0;
		for (int i = NUM-1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				victim_ok = 1'b1;
				victim = line_idx_t'(i);
			end
		end
		if (!victim_ok) begin
			for (int i = NUM-1; i >= 0; i--) begin
				if (use_q[i] == '0 && !match[i]) begin
					victim_ok = 1'b1;
					victim = line_idx_t'(i);
				end
			end
		end
	end

	assign fill = line_wr.valid && !(|dup) && victim_ok;	// else dropped

	assign age_tick = age_cnt == AGE_BITS'(`TC_AGE_INTERVAL-1);

	always_ff @(posedge clk) begin
		if (reset)
			age_cnt <= '0;
		else if (age_tick)
			age_cnt <= '0;
		else
			age_cnt <= age_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM; i++) begin
			if (reset || invalidate) begin
				valid_q[i] <= 1'b0;
				use_q[i] <= '0;
			end else if (fill && victim == line_idx_t'(i)) begin
				valid_q[i] <= 1'b1;
				use_q[i] <= USE_BITS'(`TC_USE_FILL);
			end else if (use_bump && use_bump_idx == line_idx_t'(i)) begin
				if (use_q[i] != USE_BITS'(`TC_USE_MAX))
					use_q[i] <= use_q[i] + 1'b1;	// saturating
			end else if (age_tick && use_q[i] != '0) begin
				use_q[i] <= use_q[i] - 1'b1;
			end
		end
	end

	// line contents
	always_ff @(posedge clk) begin
		if (fill) begin
			tag_q[victim] <= line_wr.tag;
			mask_q[victim] <= line_wr.mask;
			data_q[victim] <= line_wr.data;
			next_q[victim] <= line_wr.next_pc;
		end
	end

endmodule

`default_nettype wire

//--- source/trace_fetch_stage.sv
//////////////////////////////////////////////////
// fetch stage of the trace cache
// registers the store's lookup for rename and
// holds it while rename stalls; hits that rename
// consumes go back to the store as use bumps
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "trace_defs.svh"

module trace_fetch_stage import trace_pkg::*; (
	input  wire logic	clk,
	input  wire logic	reset,
	input  wire logic	rename_stall,
	input  wire logic	pc_used,
	input  wire lookup_t	lookup,
	output lookup_t		trace_out,
	output logic		use_bump,
	output line_idx_t	use_bump_idx
);

	// trace_out follows fetch_pc by one cycle
	always_ff @(posedge clk) begin
		if (reset)
			trace_out.hit <= 1'b0;
		else if (!rename_stall)
			trace_out <= lookup;	// hold under stall
	end

	// a consumed hit keeps its line away from eviction
	assign use_bump = pc_used && trace_out.hit;
	assign use_bump_idx = trace_out.idx;

endmodule

`default_nettype wire

//--- source/trace_cache.sv
//////////////////////////////////////////////////
// trace cache top level
// retired instructions in, trace lines out to
// rename; builder feeds the store, the fetch stage
// registers lookups and returns use feedback
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "trace_defs.svh"

module trace_cache import trace_pkg::*; (
	input  wire logic	clk,
	input  wire logic	reset,
	input  wire logic	invalidate,		// empties the whole cache
	input  wire logic	retire_valid,
	input  wire trace_ins_t	retire_ins,
	input  wire pc_t	fetch_pc,
	input  wire logic	rename_stall,
	input  wire logic	pc_used,		// rename took trace_out
	output lookup_t		trace_out
);

	line_write_t	line_wr;
	lookup_t		lookup;
	logic			use_bump;
	line_idx_t		use_bump_idx;

	trace_line_builder u_builder (
		.clk			(clk),
		.reset			(reset),
		.invalidate		(invalidate),
		.retire_valid	(retire_valid),
		.retire_ins		(retire_ins),
		.line_wr		(line_wr)
	);

	trace_line_store u_store (
		.clk			(clk),
		.reset			(reset),
		.invalidate		(invalidate),
		.line_wr		(line_wr),
		.fetch_pc		(fetch_pc),
		.use_bump		(use_bump),
		.use_bump_idx	(use_bump_idx),
		.lookup			(lookup)
	);

	trace_fetch_stage u_fetch (
		.clk			(clk),
		.reset			(reset),
		.rename_stall	(rename_stall),
		.pc_used		(pc_used),
		.lookup			(lookup),
		.trace_out		(trace_out),
		.use_bump		(use_bump),
		.use_bump_idx	(use_bump_idx)
	);

endmodule

`default_nettype wire

//--- dv/trace_cache_tb.sv
//////////////////////////////////////////////////
// testbench for the trace cache
// retires random instruction runs, rebuilds the
// expected trace lines in a model queue and checks
// lookups, stall hold and invalidate on trace_out
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "trace_defs.svh"

module trace_cache_tb import trace_pkg::*; ();

	localparam int SB = $clog2(`TC_LINE_SLOTS);
	localparam int HIT_TIMEOUT = 20;	// cycles to wait for a line to show up
	localparam slot_mask_t FULL_MASK = '1;

	logic		clk = 1'b0;
	logic		reset, invalidate, retire_valid, rename_stall, pc_used;
	trace_ins_t	retire_ins;
	pc_t		fetch_pc;
	lookup_t	trace_out;

	logic [31:0]lcg_state = 32'ha7a91093;
	int			region = 0;		// keeps start pcs of runs apart
	int			errors = 0;
	int			errors_at_start = 0;
	int			tests_run = 0;
	int			tests_failed = 0;

	// model of the line builder, closed lines queue up in exp_q
	line_write_t	exp_q[$];
	logic			m_open;
	pc_t			m_tag;
	pc_t			m_expect;
	slot_mask_t		m_mask;
	trace_line_t	m_line;
	int				m_count;

	trace_cache dut0 (
		.clk			(clk),
		.reset			(reset),
		.invalidate		(invalidate),
		.retire_valid	(retire_valid),
		.retire_ins		(retire_ins),
		.fetch_pc		(fetch_pc),
		.rename_stall	(rename_stall),
		.pc_used		(pc_used),
		.trace_out		(trace_out)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic pc_t fresh_pc();
		region++;
		return pc_t'(32'h1000_0000 + (region << 12)) + ((rand_next() >> 20) & 32'h0000_00fe);
	endfunction

	// where program order goes after an instruction
	function automatic pc_t seq_next(trace_ins_t ins);
		if (ins.kind == INS_JUMP || ins.kind == INS_CALL || ins.kind == INS_RETURN)
			return ins.target;
		else if (ins.short_ins)
			return ins.pc + 32'd2;
		else
			return ins.pc + 32'd4;
	endfunction

	function automatic trace_ins_t make_ins(pc_t pc, ins_kind_t kind, pc_t target, logic trap);
		trace_ins_t ins;
		logic [31:0] r;
		r = rand_next();
		ins.pc = pc;
		ins.insn = rand_next();
		ins.short_ins = r[27];
		ins.kind = kind;
		ins.target = target;
		ins.will_trap = trap;
		return ins;
	endfunction

	function automatic void push_line();
		line_write_t w;
		w.valid = 1'b1;
		w.tag = m_tag;
		w.mask = m_mask;
		w.data = m_line;
		w.next_pc = m_expect;
		exp_q.push_back(w);
		m_open = 1'b0;
	endfunction

	function automatic void model_retire(trace_ins_t ins);
		trace_ins_t st;
		logic [SB-1:0] idx;
		st = ins;
		st.will_trap = 1'b0;
		if (ins.will_trap) begin
			m_open = 1'b0;	// partial line is lost
			return;
		end
		if (m_open && ins.pc != m_expect)
			push_line();	// pc break closes the open line
		if (!m_open) begin
			m_open = 1'b1;
			m_tag = ins.pc;
			m_mask = '0;
			m_line = '0;
			m_count = 0;
		end
		idx = m_count[SB-1:0];
		m_line[idx] = st;
		m_mask[idx] = 1'b1;
		m_count++;
		m_expect = seq_next(ins);
		if (m_count == `TC_LINE_SLOTS || ins.kind == INS_CALL || ins.kind == INS_RETURN)
			push_line();
	endfunction

	task automatic retire_one(trace_ins_t ins);
		@(posedge clk);
		retire_valid <= 1'b1;
		retire_ins <= ins;
		model_retire(ins);
	endtask

	task automatic retire_stop();
		@(posedge clk);
		retire_valid <= 1'b0;
	endtask

	// plain sequential run, pc comes back where the run would continue
	task automatic retire_run(inout pc_t pc, input int len);
		trace_ins_t ins;
		for (int i = 0; i < len; i++) begin
			ins = make_ins(pc, INS_PLAIN, '0, 1'b0);
			retire_one(ins);
			pc = seq_next(ins);
		end
	endtask

	// an unrelated pc closes whatever line is open
	task automatic retire_break();
		retire_one(make_ins(fresh_pc(), INS_PLAIN, '0, 1'b0));
		retire_stop();
	endtask

	task automatic pulse_invalidate();
		@(posedge clk);
		invalidate <= 1'b1;
		@(posedge clk);
		invalidate <= 1'b0;
		exp_q.delete();
		m_open = 1'b0;
	endtask

	task automatic lookup_once(pc_t pc);
		@(posedge clk);
		fetch_pc <= pc;
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic wait_hit(pc_t pc);
		int n;
		n = 0;
		@(posedge clk);
		fetch_pc <= pc;
		pc_used <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		while (!trace_out.hit && n < HIT_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!trace_out.hit) begin
			$display("timeout: fetch pc %h never hit within %0d cycles", pc, HIT_TIMEOUT);
			errors++;
		end
	endtask

	task automatic report_mismatch(string name, logic [511:0] expected, logic [511:0] actual);
		$display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
		errors++;
	endtask

	// lines filled since the last invalidate take indices in fill order
	task automatic check_line(line_write_t e, int pos);
		line_idx_t exp_idx;
		exp_idx = line_idx_t'(pos);
		if (trace_out.hit !== 1'b1)
			report_mismatch("trace_out.hit", 512'(1'b1), 512'(trace_out.hit));
		if (trace_out.idx !== exp_idx)
			report_mismatch("trace_out.idx", 512'(exp_idx), 512'(trace_out.idx));
		if (trace_out.mask !== e.mask)
			report_mismatch("trace_out.mask", 512'(e.mask), 512'(trace_out.mask));
		if (trace_out.data !== e.data)
			report_mismatch("trace_out.data", 512'(e.data), 512'(trace_out.data));
		if (trace_out.next_pc !== e.next_pc)
			report_mismatch("trace_out.next_pc", 512'(e.next_pc), 512'(trace_out.next_pc));
	endtask

	task automatic begin_test();
		errors_at_start = errors;
		pulse_invalidate();
	endtask

	task automatic end_test(string name);
		tests_run++;
		if (errors != errors_at_start)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name,
			(errors == errors_at_start) ? "ok" : "errors");
	endtask

	initial begin
		pc_t pc, pc_a, pc_b, pc_c;
		pc_t old_tags[$];
		lookup_t snap;
		int len;
		reset <= 1'b1;
		invalidate <= 1'b0;
		retire_valid <= 1'b0;
		retire_ins <= '0;
		fetch_pc <= '0;
		rename_stall <= 1'b0;
		pc_used <= 1'b0;
		m_open = 1'b0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		begin_test();
		for (int r = 0; r < 3; r++) begin
			pc = fresh_pc();
			len = 1 + int'((rand_next() >> 28) & 32'h7);
			retire_run(pc, len);
		end
		retire_break();
		foreach (exp_q[i]) begin
			wait_hit(exp_q[i].tag);
			check_line(exp_q[i], i);
		end
		end_test("fill and hit");

		begin_test();
		pc = fresh_pc();
		retire_run(pc, 10);
		retire_stop();
		pc_c = m_tag;	// third line, still open
		for (int i = 0; i < 2; i++) begin
			wait_hit(exp_q[i].tag);
			check_line(exp_q[i], i);
			if (trace_out.mask !== FULL_MASK)
				report_mismatch("trace_out.mask", 512'(FULL_MASK), 512'(trace_out.mask));
			pc_a = (i == 0) ? exp_q[1].tag : pc_c;
			if (trace_out.next_pc !== pc_a)
				report_mismatch("trace_out.next_pc", 512'(pc_a), 512'(trace_out.next_pc));
		end
		lookup_once(pc_c);
		if (trace_out.hit !== 1'b0)
			report_mismatch("trace_out.hit", 512'(1'b0), 512'(trace_out.hit));
		retire_break();
		wait_hit(pc_c);
		check_line(exp_q[2], 2);
		if (trace_out.mask !== slot_mask_t'(3))
			report_mismatch("trace_out.mask", 512'(3), 512'(trace_out.mask));
		end_test("full line split");

		begin_test();
		pc_c = fresh_pc();
		pc_a = fresh_pc();	// call target
		pc_b = fresh_pc();	// return target
		pc = pc_c;
		retire_run(pc, 2);
		retire_one(make_ins(pc, INS_CALL, pc_a, 1'b0));
		pc = pc_a;
		retire_run(pc, 1);
		retire_one(make_ins(pc, INS_RETURN, pc_b, 1'b0));
		pc = pc_b;
		retire_run(pc, 1);
		retire_break();
		wait_hit(pc_c);
		check_line(exp_q[0], 0);
		if (trace_out.next_pc !== pc_a)
			report_mismatch("trace_out.next_pc", 512'(pc_a), 512'(trace_out.next_pc));
		wait_hit(pc_a);
		check_line(exp_q[1], 1);
		if (trace_out.next_pc !== pc_b)
			report_mismatch("trace_out.next_pc", 512'(pc_b), 512'(trace_out.next_pc));
		wait_hit(pc_b);
		check_line(exp_q[2], 2);
		end_test("call and return");

		begin_test();
		pc_a = fresh_pc();
		pc = pc_a;
		retire_run(pc, 2);
		retire_one(make_ins(pc, INS_PLAIN, '0, 1'b1));
		pc_b = fresh_pc();
		pc = pc_b;
		retire_run(pc, 3);
		retire_break();
		wait_hit(pc_b);
		check_line(exp_q[0], 0);
		lookup_once(pc_a);
		if (trace_out.hit !== 1'b0)
			report_mismatch("trace_out.hit", 512'(1'b0), 512'(trace_out.hit));
		end_test("trap discard");

		begin_test();
		pc_a = fresh_pc();
		pc = pc_a;
		retire_run(pc, 3);
		pc_b = fresh_pc();
		pc = pc_b;
		retire_run(pc, 2);
		retire_break();
		pc_c = fresh_pc();	// never filled
		wait_hit(pc_a);
		check_line(exp_q[0], 0);
		snap = trace_out;
		@(posedge clk);
		rename_stall <= 1'b1;
		fetch_pc <= pc_b;
		for (int k = 0; k < 6; k++) begin
			@(posedge clk);
			fetch_pc <= (k % 3 == 0) ? pc_c : ((k % 3 == 1) ? pc_b : pc_a);
			@(negedge clk);
			if (trace_out !== snap)
				report_mismatch("trace_out", 512'(snap), 512'(trace_out));
		end
		@(posedge clk);
		rename_stall <= 1'b0;
		fetch_pc <= pc_b;
		@(posedge clk);
		@(negedge clk);
		check_line(exp_q[1], 1);
		lookup_once(pc_c);
		if (trace_out.hit !== 1'b0)
			report_mismatch("trace_out.hit", 512'(1'b0), 512'(trace_out.hit));
		end_test("stall hold");

		begin_test();
		pc = fresh_pc();
		retire_run(pc, 5);
		pc = fresh_pc();
		retire_run(pc, 2);
		retire_break();
		foreach (exp_q[i]) begin
			wait_hit(exp_q[i].tag);
			check_line(exp_q[i], i);
			old_tags.push_back(exp_q[i].tag);
		end
		pulse_invalidate();
		foreach (old_tags[i]) begin
			lookup_once(old_tags[i]);
			if (trace_out.hit !== 1'b0)
				report_mismatch("trace_out.hit", 512'(1'b0), 512'(trace_out.hit));
		end
		pc = old_tags[0];
		retire_run(pc, 3);
		retire_break();
		wait_hit(old_tags[0]);
		check_line(exp_q[0], 0);
		end_test("invalidate");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+source
source/trace_pkg.sv
source/trace_line_builder.sv
source/trace_line_store.sv
source/trace_fetch_stage.sv
source/trace_cache.sv
dv/trace_cache_tb.sv

//--- Makefile
# Verilator build and run for the trace cache testbench
# override any variable on the command line, e.g. make LOG=run2.log

VERILATOR  ?= verilator
TOP        ?= trace_cache_tb
RTL_TOP    ?= trace_cache
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Something failed" $(LOG); then exit 1; fi; exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
